// File: Makefile
TOP = tb_io_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f build.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '\*\*\* PASSED \*\*\*'

clean:
	rm -rf obj_dir

// File: build.f
common/io_pkg.sv
hdl/io_addr_decoder.sv
hdl/io_bus_ctrl.sv
hdl/io_config_regs.sv
pit/io_pit.sv
hdl/io_subsystem.sv
tb/tb_io_subsystem.sv

// File: common/io_pkg.sv
// Shared bus types, controller states and I/O map constants, imported by every RTL module
package io_pkg;

    // Word address on the CPU bus, bit 0 is implied by word access
    typedef logic [19:1] io_addr_t;

    // One 16-bit bus data word
    typedef logic [15:0] io_data_t;

    // Controller sequence for one four-phase access
    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        STROBE,
        RESPOND,
        RELEASE
    } bus_state_e;

    // Byte addresses in I/O space
    localparam logic [15:0] IO_LEDS_ADDR      = 16'hFFFE;
    localparam logic [15:0] IO_SDRAM_CFG_ADDR = 16'hFFFC;
    // Base of the 8-byte PIT window, 40h to 47h
    localparam logic [15:0] IO_PIT_BASE       = 16'h0040;

    // PIT register offsets, taken from address bits 2:1
    localparam logic [1:0] PIT_RELOAD  = 2'd0;
    // Bit 0 enables counting
    localparam logic [1:0] PIT_CONTROL = 2'd1;
    // Current count, read only
    localparam logic [1:0] PIT_COUNT   = 2'd2;
    // Bit 0 is the terminal-count flag, write 1 to clear
    localparam logic [1:0] PIT_STATUS  = 2'd3;

    // Read data for unmapped I/O
    localparam logic [15:0] IO_DEFAULT_RDATA = 16'hFFFF;

endpackage

// File: hdl/io_addr_decoder.sv
// Combinational I/O address decoder, picks one target select for the bus controller
`timescale 1ns/1ns

module io_addr_decoder
    import io_pkg::*;
(
    // Bus side, from the controller
    input  logic     d_io,
    input  io_addr_t data_m_addr,
    input  logic     data_m_access,

    // Target selects
    output logic     leds_access,
    output logic     sdram_config_access,
    output logic     timer_access,
    output logic     default_io_access
);

    // Address compare results, bits 19:17 are outside the 64K I/O space
    logic hit_leds;
    logic hit_sdram;
    logic hit_pit;

    // LED and SDRAM words are single word addresses
    assign hit_leds  = (data_m_addr[16:1] == {1'b0, IO_LEDS_ADDR[15:1]});
    assign hit_sdram = (data_m_addr[16:1] == {1'b0, IO_SDRAM_CFG_ADDR[15:1]});

    // PIT owns an 8-byte window, so only bits 16:3 take part
    assign hit_pit   = (data_m_addr[16:3] == {1'b0, IO_PIT_BASE[15:3]});

    always_comb begin
        // Nothing selected by default
        leds_access         = 1'b0;
        sdram_config_access = 1'b0;
        timer_access        = 1'b0;
        default_io_access   = 1'b0;

        // Memory cycles and idle bus select nothing
        if (d_io && data_m_access) begin
            // Priority order: LED word, SDRAM word, then PIT window
            if (hit_leds) begin
                leds_access = 1'b1;
            end else if (hit_sdram) begin
                sdram_config_access = 1'b1;
            end else if (hit_pit) begin
                timer_access = 1'b1;
            end else begin
                // Unmapped port, answered by the default responder
                default_io_access = 1'b1;
            end
        end
    end

    // Controller muxes read data assuming a single owner
    always_comb begin
        assert ($onehot0({leds_access, sdram_config_access, timer_access,
                          default_io_access}))
        else $error("decoder raised more than one select at %h", data_m_addr);
    end

endmodule

// File: hdl/io_bus_ctrl.sv
// Four-phase bus controller, sequences each access through decode, strobe and response
`timescale 1ns/1ns

module io_bus_ctrl
    import io_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // CPU-side four-phase bus
    input  logic     req,
    input  logic     io_space,
    input  io_addr_t addr,
    input  logic     wr,
    input  io_data_t wdata,
    output logic     ack,
    output io_data_t rdata,

    // Decoder side
    output logic     d_io,
    output io_addr_t data_m_addr,
    output logic     data_m_access,
    input  logic     leds_access,
    input  logic     sdram_config_access,
    input  logic     timer_access,
    input  logic     default_io_access,

    // Target side
    output logic     cfg_stb,
    output logic     pit_stb,
    output logic     reg_wr,
    output io_addr_t reg_addr,
    output io_data_t reg_wdata,
    input  io_data_t cfg_rdata,
    input  io_data_t pit_rdata
);

    bus_state_e state;

    // Selects registered in DECODE, held until the next access
    logic sel_cfg;
    logic sel_pit;
    logic sel_default;

    // Read data chosen for the response
    io_data_t resp_data;

    // Decoder looks at the latched address for two cycles
    assign data_m_access = (state == DECODE) || (state == STROBE);

    // Targets see the same latched address
    assign reg_addr = data_m_addr;

    // One-cycle strobes, only for the owning target
    assign cfg_stb = (state == STROBE) && sel_cfg;
    assign pit_stb = (state == STROBE) && sel_pit;

    always_comb begin
        if (sel_cfg) begin
            resp_data = cfg_rdata;
        end else if (sel_pit) begin
            resp_data = pit_rdata;
        end else if (sel_default) begin
            resp_data = IO_DEFAULT_RDATA;
        end else begin
            // Memory-space cycle
            resp_data = '0;
        end
    end

    // Sequencer and ack
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            ack         <= 1'b0;
            sel_cfg     <= 1'b0;
            sel_pit     <= 1'b0;
            sel_default <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    // Both config registers live in one block
                    sel_cfg     <= leds_access | sdram_config_access;
                    sel_pit     <= timer_access;
                    sel_default <= default_io_access;
                    state       <= STROBE;
                end
                STROBE: begin
                    state <= RESPOND;
                end
                RESPOND: begin
                    ack   <= 1'b1;
                    state <= RELEASE;
                end
                RELEASE: begin
                    // Master holds req for back-pressure
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request latch and response data
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req) begin
            d_io        <= io_space;
            data_m_addr <= addr;
            reg_wr      <= wr;
            reg_wdata   <= wdata;
        end
        // Target data was registered on the strobe edge
        if (state == RESPOND) begin
            rdata <= resp_data;
        end
    end

    // Four-phase rule on the outgoing edge, req as seen on the edge that raised ack
    assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req))
    else $error("ack rose with req low");

    // One target strobed per access
    assert property (@(posedge clk) disable iff (reset) $onehot0({cfg_stb, pit_stb}))
    else $error("more than one target strobe");

endmodule

// File: hdl/io_config_regs.sv
// LED port and SDRAM configuration word, written and read back over the I/O bus
`timescale 1ns/1ns

module io_config_regs
    import io_pkg::*;
#(
    parameter int LED_WIDTH = 8
) (
    input  logic                 clk,
    input  logic                 reset,

    // Strobe and selects from controller and decoder
    input  logic                 stb,
    input  logic                 wr,
    input  logic                 leds_access,
    input  logic                 sdram_config_access,
    input  io_data_t             wdata,
    output io_data_t             rdata,

    // Register outputs to the board
    output logic [LED_WIDTH-1:0] leds,
    output io_data_t             sdram_config
);

    // Writes land on the strobe edge
    always_ff @(posedge clk) begin
        if (reset) begin
            leds         <= '0;
            sdram_config <= '0;
        end else if (stb && wr) begin
            if (leds_access) begin
                // Upper data bits are dropped
                leds <= wdata[LED_WIDTH-1:0];
            end
            if (sdram_config_access) begin
                sdram_config <= wdata;
            end
        end
    end

    // Read-back, valid the cycle after the strobe
    always_ff @(posedge clk) begin
        if (stb) begin
            if (leds_access) begin
                // Zero-extended to a full word
                rdata <= io_data_t'(leds);
            end else begin
                rdata <= sdram_config;
            end
        end
    end

    // Decoder must name exactly one register on every strobe
    assert property (@(posedge clk) disable iff (reset)
        stb |-> $onehot({leds_access, sdram_config_access}))
    else $error("config strobe without a single register select");

endmodule

// File: hdl/io_subsystem.sv
// I/O-space top level, joins bus controller, address decoder, config registers and timer
`timescale 1ns/1ns

module io_subsystem
    import io_pkg::*;
#(
    parameter int LED_WIDTH  = 8,
    parameter int PIT_DIVIDE = 4
) (
    input  logic                 clk,
    input  logic                 reset,

    // CPU-side four-phase bus
    input  logic                 req,
    input  logic                 io_space,
    input  io_addr_t             addr,
    input  logic                 wr,
    input  io_data_t             wdata,
    output logic                 ack,
    output io_data_t             rdata,

    // Board outputs
    output logic [LED_WIDTH-1:0] leds,
    output io_data_t             sdram_config,
    output logic                 timer_irq
);

    // Controller to decoder
    logic     d_io;
    io_addr_t data_m_addr;
    logic     data_m_access;
    logic     leds_access;
    logic     sdram_config_access;
    logic     timer_access;
    logic     default_io_access;

    // Controller to targets
    logic     cfg_stb;
    logic     pit_stb;
    logic     reg_wr;
    io_addr_t reg_addr;
    io_data_t reg_wdata;
    io_data_t cfg_rdata;
    io_data_t pit_rdata;

    io_bus_ctrl i_bus_ctrl (
        .clk, .reset, .req, .io_space, .addr, .wr, .wdata, .ack, .rdata,
        .d_io, .data_m_addr, .data_m_access,
        .leds_access, .sdram_config_access, .timer_access, .default_io_access,
        .cfg_stb, .pit_stb, .reg_wr, .reg_addr, .reg_wdata, .cfg_rdata, .pit_rdata
    );

    io_addr_decoder i_addr_decoder (
        .d_io, .data_m_addr, .data_m_access,
        .leds_access, .sdram_config_access, .timer_access, .default_io_access
    );

    // Selects stay valid through the strobe cycle
    io_config_regs #(.LED_WIDTH(LED_WIDTH)) i_config_regs (
        .clk, .reset, .stb(cfg_stb), .wr(reg_wr),
        .leds_access, .sdram_config_access,
        .wdata(reg_wdata), .rdata(cfg_rdata), .leds, .sdram_config
    );

    io_pit #(.PIT_DIVIDE(PIT_DIVIDE)) i_pit (
        .clk, .reset, .stb(pit_stb), .wr(reg_wr), .reg_addr,
        .wdata(reg_wdata), .rdata(pit_rdata), .timer_irq
    );

endmodule

// File: pit/io_pit.sv
// Interval timer in the PIT window, prescaled down-counter with reload, flag and interrupt
`timescale 1ns/1ns

module io_pit
    import io_pkg::*;
#(
    parameter int PIT_DIVIDE = 4
) (
    input  logic     clk,
    input  logic     reset,

    // Register access from the bus controller
    input  logic     stb,
    input  logic     wr,
    input  io_addr_t reg_addr,
    input  io_data_t wdata,
    output io_data_t rdata,

    // One-clock pulse on terminal count
    output logic     timer_irq
);

    // Prescaler needs at least one bit
    localparam int PRE_W = (PIT_DIVIDE > 1) ? $clog2(PIT_DIVIDE) : 1;

    io_data_t         reload;
    io_data_t         count;
    logic             enable;
    logic             flag;
    logic [PRE_W-1:0] prescale;

    // Decrement enable, once every PIT_DIVIDE clocks
    logic tick;
    // Register write decode
    logic wr_reload;
    logic wr_control;
    logic wr_status;

    assign tick       = enable && (prescale == PRE_W'(PIT_DIVIDE - 1));
    assign wr_reload  = stb && wr && (reg_addr[2:1] == PIT_RELOAD);
    assign wr_control = stb && wr && (reg_addr[2:1] == PIT_CONTROL);
    assign wr_status  = stb && wr && (reg_addr[2:1] == PIT_STATUS);

    always_ff @(posedge clk) begin
        if (reset) begin
            reload    <= '0;
            count     <= '0;
            enable    <= 1'b0;
            flag      <= 1'b0;
            prescale  <= '0;
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= 1'b0;

            // Prescaler holds while disabled
            if (tick) begin
                prescale <= '0;
            end else if (enable) begin
                prescale <= prescale + 1'b1;
            end

            // Clear before set, so a new terminal count is never lost
            if (wr_status && wdata[0]) begin
                flag <= 1'b0;
            end

            if (wr_reload) begin
                // New period starts from the full reload value
                reload   <= wdata;
                count    <= wdata;
                prescale <= '0;
            end else if (tick) begin
                if (count == '0) begin
                    count     <= reload;
                    flag      <= 1'b1;
                    timer_irq <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end

            if (wr_control) begin
                enable <= wdata[0];
            end
        end
    end

    // Read mux, valid the cycle after the strobe
    always_ff @(posedge clk) begin
        if (stb) begin
            case (reg_addr[2:1])
                PIT_RELOAD:  rdata <= reload;
                PIT_CONTROL: rdata <= {15'd0, enable};
                PIT_COUNT:   rdata <= count;
                default:     rdata <= {15'd0, flag};
            endcase
        end
    end

    // Count stays inside the programmed period
    assert property (@(posedge clk) disable iff (reset) enable |-> (count <= reload))
    else $error("PIT count %h above reload %h", count, reload);

endmodule

// File: tb/tb_io_subsystem.sv
// Directed testbench for the I/O subsystem, drives four-phase bus cycles and checks every target
`timescale 1ns/1ns

module tb_io_subsystem
    import io_pkg::*;
();

    localparam int LED_WIDTH   = 8;
    localparam int PIT_DIVIDE  = 4;
    localparam int ACK_TIMEOUT = 20;
    localparam int POLL_LIMIT  = 50;
    // LED bits that survive the register width
    localparam io_data_t LED_MASK = io_data_t'((1 << LED_WIDTH) - 1);

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 req;
    logic                 io_space;
    io_addr_t             addr;
    logic                 wr;
    io_data_t             wdata;
    logic                 ack;
    io_data_t             rdata;
    logic [LED_WIDTH-1:0] leds;
    io_data_t             sdram_config;
    logic                 timer_irq;

    int unsigned seed_result;
    // Running total of interrupt pulses
    int          irq_pulses = 0;

    io_subsystem #(
        .LED_WIDTH(LED_WIDTH),
        .PIT_DIVIDE(PIT_DIVIDE)
    ) i_io_subsystem (
        .clk, .reset, .req, .io_space, .addr, .wr, .wdata, .ack, .rdata,
        .leds, .sdram_config, .timer_irq
    );

    // 40 ns period
    always #20 clk = ~clk;

    // Sampled mid-cycle, the pulse lasts a full clock
    always @(negedge clk) begin
        if (timer_irq) begin
            irq_pulses = irq_pulses + 1;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input io_data_t got,
                               input io_data_t expected);
        if (got !== expected) begin
            fail_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, expected));
        end
    endtask

    // Byte address to bus word address
    function automatic io_addr_t word_addr(input logic [15:0] byte_addr);
        return {4'b0000, byte_addr[15:1]};
    endfunction

    // Byte address of a register in the PIT window
    function automatic logic [15:0] pit_addr(input logic [1:0] offset);
        return IO_PIT_BASE | {13'd0, offset, 1'b0};
    endfunction

    // Full four-phase cycle, with req-to-ack latency and release checked
    task automatic bus_access(input logic space, input logic write,
                              input logic [15:0] byte_addr, input io_data_t data,
                              output io_data_t read_data);
        int cycles;
        @(posedge clk);
        #2;
        io_space = space;
        addr     = word_addr(byte_addr);
        wr       = write;
        wdata    = data;
        req      = 1'b1;
        cycles   = 0;
        while (!ack && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ack) begin
            fail_run("timeout waiting for ack to rise");
        end
        check_value("ack latency in clocks", io_data_t'(cycles), 16'd4);
        read_data = rdata;
        #1;
        // Release phase
        req    = 1'b0;
        cycles = 0;
        while (ack && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (ack) begin
            fail_run("timeout waiting for ack to fall");
        end
        check_value("ack release latency in clocks", io_data_t'(cycles), 16'd1);
    endtask

    task automatic io_write(input logic [15:0] byte_addr, input io_data_t data);
        io_data_t unused_data;
        bus_access(1'b1, 1'b1, byte_addr, data, unused_data);
    endtask

    task automatic io_read(input logic [15:0] byte_addr, output io_data_t data);
        bus_access(1'b1, 1'b0, byte_addr, 16'h0000, data);
    endtask

    task automatic check_count_range(input io_data_t count, input io_data_t reload_n);
        if (count > reload_n) begin
            fail_run($sformatf("[FAIL] PIT_COUNT: got %h, above reload %h", count, reload_n));
        end
    endtask

    task automatic check_reset_state();
        check_value("ack", io_data_t'(ack), 16'h0000);
        check_value("timer_irq", io_data_t'(timer_irq), 16'h0000);
        check_value("leds", io_data_t'(leds), 16'h0000);
        check_value("sdram_config", sdram_config, 16'h0000);
    endtask

    // Random values through both config registers, outputs and read-back
    task automatic test_config_regs();
        io_data_t led_val;
        io_data_t sdram_val;
        io_data_t value;
        for (int i = 0; i < 4; i++) begin
            led_val   = io_data_t'($urandom);
            sdram_val = io_data_t'($urandom);
            io_write(IO_LEDS_ADDR, led_val);
            check_value("leds", io_data_t'(leds), led_val & LED_MASK);
            io_write(IO_SDRAM_CFG_ADDR, sdram_val);
            check_value("sdram_config", sdram_config, sdram_val);
            io_read(IO_LEDS_ADDR, value);
            check_value("rdata LED read-back", value, led_val & LED_MASK);
            io_read(IO_SDRAM_CFG_ADDR, value);
            check_value("rdata SDRAM read-back", value, sdram_val);
        end
    endtask

    // Default responder and memory-space cycles
    task automatic test_unmapped_and_memory();
        io_data_t led_before;
        io_data_t sdram_before;
        io_data_t value;
        led_before   = io_data_t'(leds);
        sdram_before = sdram_config;
        io_read(16'h0300, value);
        check_value("rdata unmapped I/O", value, 16'hFFFF);
        // Memory writes aimed at the config addresses must miss
        bus_access(1'b0, 1'b1, IO_LEDS_ADDR, ~led_before, value);
        check_value("rdata memory write", value, 16'h0000);
        bus_access(1'b0, 1'b1, IO_SDRAM_CFG_ADDR, ~sdram_before, value);
        check_value("rdata memory write", value, 16'h0000);
        bus_access(1'b0, 1'b0, IO_SDRAM_CFG_ADDR, 16'h0000, value);
        check_value("rdata memory read", value, 16'h0000);
        check_value("leds", io_data_t'(leds), led_before);
        check_value("sdram_config", sdram_config, sdram_before);
        io_read(IO_SDRAM_CFG_ADDR, value);
        check_value("rdata SDRAM read-back", value, sdram_before);
    endtask

    // Reload, enable, then poll until terminal count
    task automatic test_pit_run(output io_data_t reload_n);
        io_data_t value;
        logic     flag_seen;
        int       polls;
        int       irq_before;
        // Long enough period that a clear and a read fit before the next terminal count
        reload_n = io_data_t'(16 + ($urandom % 16));
        io_write(pit_addr(PIT_RELOAD), reload_n);
        io_read(pit_addr(PIT_RELOAD), value);
        check_value("rdata PIT_RELOAD", value, reload_n);
        io_read(pit_addr(PIT_COUNT), value);
        check_value("rdata PIT_COUNT", value, reload_n);
        irq_before = irq_pulses;
        io_write(pit_addr(PIT_CONTROL), 16'h0001);
        io_read(pit_addr(PIT_CONTROL), value);
        check_value("rdata PIT_CONTROL", value, 16'h0001);
        polls     = 0;
        flag_seen = 1'b0;
        while (!flag_seen && polls < POLL_LIMIT) begin
            io_read(pit_addr(PIT_COUNT), value);
            check_count_range(value, reload_n);
            io_read(pit_addr(PIT_STATUS), value);
            flag_seen = value[0];
            polls++;
        end
        if (!flag_seen) begin
            fail_run("timeout waiting for the PIT terminal-count flag");
        end
        if (irq_pulses == irq_before) begin
            fail_run("timer_irq did not pulse before the terminal-count flag was seen");
        end
    endtask

    // Flag clear, then disable and confirm the count holds
    task automatic test_pit_clear_and_freeze(input io_data_t reload_n);
        io_data_t first_count;
        io_data_t second_count;
        io_data_t value;
        io_write(pit_addr(PIT_STATUS), 16'h0001);
        io_read(pit_addr(PIT_STATUS), value);
        check_value("rdata PIT_STATUS after clear", value, 16'h0000);
        io_write(pit_addr(PIT_CONTROL), 16'h0000);
        io_read(pit_addr(PIT_COUNT), first_count);
        check_count_range(first_count, reload_n);
        io_read(pit_addr(PIT_COUNT), second_count);
        check_value("rdata PIT_COUNT while disabled", second_count, first_count);
    endtask

    initial begin
        io_data_t reload_n;
        seed_result = $urandom(32'ha4cb_2567);
        reset    = 1'b1;
        req      = 1'b0;
        io_space = 1'b0;
        addr     = '0;
        wr       = 1'b0;
        wdata    = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        check_reset_state();
        test_config_regs();
        test_unmapped_and_memory();
        test_pit_run(reload_n);
        test_pit_clear_and_freeze(reload_n);
        $display("*** PASSED ***");
        $finish;
    end

endmodule
